//--- project.f
+incdir+include
source/fds_audio_pkg.sv
source/fds_reg_decode.sv
source/fds_wave_channel.sv
source/fds_vol_envelope.sv
source/fds_level_mix.sv
source/fds_audio_top.sv
verification/fds_audio_checker.sv
verification/fds_audio_tb.sv

//--- Makefile
# Verilator flow for the fds sound unit: lint, simulation and cleanup

VERILATOR ?= verilator
TOP       ?= fds_audio_tb
RTL_TOP   ?= fds_audio_top
SEED      ?= 8
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

# rtl on its own, then the testbench on top of it
lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

# build and run, status comes from the pass line
sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/fds_audio_tb.sv
// testbench top with clock, reset, xorshift stimulus, wishbone master tasks, reference model, report
`timescale 1ns/1ps
`default_nettype none
`include "fds_audio_defs.svh"

module fds_audio_tb;
	parameter logic [31:0] SEED = 32'd8;
	localparam int ACK_TIMEOUT = 16;  // clocks

	logic                   clk20 = 1'b0;
	logic                   reset;
	logic                   m2_tick;
	logic                   cyc;
	logic                   stb;
	logic                   we;
	logic [`FDS_ADDR_W-1:0] adr;
	logic [`FDS_DATA_W-1:0] dat_w;
	wire                    ack;
	wire [`FDS_DATA_W-1:0]  dat_r;
	wire [`FDS_LEVEL_W-1:0] audio_level;

	logic [31:0] rng;
	logic        ticking;  // m2_tick generator enabled
	int          gap;      // clocks to the next m2_tick
	int          bus_errors;
	int          ack_errors;
	int          data_errors;
	int          level_errors;

	// reference model state
	logic                    exp_ack;
	logic                    exp_read;
	logic [`FDS_DATA_W-1:0]  exp_dat_r;
	logic [`FDS_LEVEL_W-1:0] exp_level;
	logic [5:0]              ref_table [64];
	logic [11:0]             ref_freq;
	logic [23:0]             ref_phase;
	logic [3:0]              ref_cycles;
	logic                    ref_halted;
	logic                    ref_wmode;      // wave write mode
	logic [5:0]              ref_latch;      // wave latch
	logic [5:0]              ref_vol_latch;
	logic [1:0]              ref_master;
	logic [5:0]              ref_gain;
	logic [5:0]              ref_vol_speed;
	logic                    ref_dir;
	logic                    ref_vol_off;
	logic                    ref_env_off;
	logic [7:0]              ref_env_speed;
	int                      ref_env_ticks;
	logic [5:0]              ref_vol_ticks;

	always #2 clk20 = ~clk20;  // 4 ns period

	fds_audio_top fds_audio_top_i (
		.clk20       (clk20),
		.reset       (reset),
		.m2_tick     (m2_tick),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.adr         (adr),
		.dat_w       (dat_w),
		.ack         (ack),
		.dat_r       (dat_r),
		.audio_level (audio_level)
	);

	fds_audio_checker checker_i (
		.clk20        (clk20),
		.reset        (reset),
		.ack          (ack),
		.dat_r        (dat_r),
		.audio_level  (audio_level),
		.exp_ack      (exp_ack),
		.exp_read     (exp_read),
		.exp_dat_r    (exp_dat_r),
		.exp_level    (exp_level),
		.ack_errors   (ack_errors),
		.data_errors  (data_errors),
		.level_errors (level_errors)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic roll(output logic [31:0] r);
		rng = xorshift32(rng);
		r   = rng;
	endtask

	// master volume scaling by 1, 2/3, 1/2 and 2/5
	function automatic logic [`FDS_LEVEL_W-1:0] scale_level(input logic [31:0] raw,
			input logic [1:0] master);
		logic [31:0] v;
		case (master)
			2'd0:    v = raw;
			2'd1:    v = raw * 2 / 3;
			2'd2:    v = raw / 2;
			default: v = raw * 2 / 5;
		endcase
		return v[`FDS_LEVEL_W-1:0];
	endfunction

	// reference model stepping once per rising edge from old state to new
	always @(posedge clk20) begin : model
		logic        req;
		logic        win;
		logic [5:0]  pidx;
		logic [5:0]  word;       // table word the bus would see
		logic [31:0] wave_v;
		logic [31:0] vol_v;
		logic [3:0]  next_cycles;
		logic [23:0] next_phase;
		logic [5:0]  next_latch;
		logic [5:0]  next_gain;
		logic [5:0]  next_vol;
		int          next_env;
		int          period;
		if (reset) begin
			{exp_ack, exp_read, exp_level} = '0;
			{ref_freq, ref_phase, ref_cycles, ref_latch, ref_vol_latch} = '0;
			{ref_wmode, ref_master, ref_gain, ref_vol_speed, ref_dir, ref_vol_off} = '0;
			ref_halted    = 1'b1;
			ref_env_off   = 1'b1;
			ref_env_speed = `FDS_ENV_SPEED_RESET;
			ref_env_ticks = 0;
			ref_vol_ticks = '0;
		end else begin
			req  = cyc && stb && !exp_ack;
			win  = adr >= `FDS_WAVE_BASE && adr <= `FDS_WAVE_LAST;
			pidx = ref_phase[23:18];
			word = ref_wmode ? ref_table[adr[5:0]] : ref_table[pidx];
			// level from the latches before this edge with volume clamped at 32
			wave_v    = {26'd0, ref_latch};
			vol_v     = (ref_vol_latch >= 6'd32) ? 32'd32 : {26'd0, ref_vol_latch};
			exp_level = scale_level(wave_v * vol_v, ref_master);
			if (pidx == 6'd0)
				ref_vol_latch = ref_gain;
			if (req && !we) begin
				if (win)
					exp_dat_r = {2'b00, word};
				else if (adr == `FDS_RD_GAIN)
					exp_dat_r = {2'b01, ref_gain};
				else if (adr == `FDS_RD_SAMPLE)
					exp_dat_r = {2'b01, word};
				else
					exp_dat_r = `FDS_RD_DEFAULT;
			end
			exp_read = req && !we;
			exp_ack  = req;

			// phase steps every 16th cpu cycle
			next_cycles = ref_cycles;
			next_phase  = ref_phase;
			next_latch  = ref_latch;
			if (m2_tick) begin
				next_cycles = ref_halted ? 4'd0 : ref_cycles + 4'd1;
				if (!ref_halted && ref_cycles == 4'd15)
					next_phase = ref_phase + {12'd0, ref_freq};
				if (!ref_wmode)
					next_latch = ref_table[pidx];
			end

			// envelope period speed*8+7 with ticks of 4 while halted
			next_env  = ref_env_ticks;
			next_vol  = ref_vol_ticks;
			next_gain = ref_gain;
			period    = {24'd0, ref_env_speed} * 8 + 7;
			if (m2_tick && !ref_env_off && !ref_vol_off && ref_env_speed != 8'd0) begin
				if (ref_env_ticks < period)
					next_env = ref_env_ticks + (ref_halted ? 4 : 1);
				else begin
					next_env = 0;
					next_vol = ref_vol_ticks + 6'd1;
					if (ref_vol_ticks == ref_vol_speed) begin
						next_vol = 6'd0;
						if (ref_dir && ref_gain < 6'd32)
							next_gain = ref_gain + 6'd1;
						else if (!ref_dir && ref_gain != 6'd0)
							next_gain = ref_gain - 6'd1;
					end
				end
			end
			ref_cycles    = next_cycles;
			ref_phase     = next_phase;
			ref_latch     = next_latch;
			ref_env_ticks = next_env;
			ref_vol_ticks = next_vol;
			ref_gain      = next_gain;

			// bus writes override the tick
			if (req && we) begin
				if (win && ref_wmode)
					ref_table[adr[5:0]] = dat_w[5:0];
				case (adr)
					`FDS_REG_VOL: begin
						{ref_vol_off, ref_dir, ref_vol_speed} = dat_w;
						if (dat_w[7])
							ref_gain = dat_w[5:0];  // direct load
						ref_env_ticks = 0;
						ref_vol_ticks = '0;
					end
					`FDS_REG_FREQ_LO: ref_freq[7:0] = dat_w;
					`FDS_REG_FREQ_HI: begin
						ref_freq[11:8] = dat_w[3:0];
						ref_halted     = dat_w[7];
						ref_env_off    = dat_w[6];
						if (dat_w[7]) begin
							ref_phase  = '0;
							ref_cycles = '0;
						end
						if (dat_w[6]) begin
							ref_env_ticks = 0;
							ref_vol_ticks = '0;
						end
					end
					`FDS_REG_MASTER: begin
						ref_wmode  = dat_w[7];
						ref_master = dat_w[1:0];
					end
					`FDS_REG_ENV_SPEED: begin
						ref_env_speed = dat_w;
						ref_env_ticks = 0;
						ref_vol_ticks = '0;
					end
					default: ;
				endcase
			end
		end
	end

	// step one clock and drive m2_tick every 2 or 3 clocks when enabled
	task automatic step_clock();
		logic [31:0] r;
		@(posedge clk20);
		#0.5;
		if (ticking && gap == 0) begin
			m2_tick = 1'b1;
			roll(r);
			gap = r[0] ? 2 : 1;
		end else begin
			m2_tick = 1'b0;
			if (gap != 0)
				gap--;
		end
	endtask

	task automatic run_clocks(input int n);
		repeat (n) step_clock();
	endtask

	// one wishbone classic cycle with ack expected on the first edge
	task automatic bus_access(input logic write, input logic [`FDS_ADDR_W-1:0] a,
			input logic [`FDS_DATA_W-1:0] d, output logic [`FDS_DATA_W-1:0] q);
		int waited;
		cyc    = 1'b1;
		stb    = 1'b1;
		we     = write;
		adr    = a;
		dat_w  = d;
		waited = 0;
		do begin
			step_clock();
			waited++;
			if (waited > ACK_TIMEOUT) begin
				$display("timeout: no ack for address %h within %0d clocks", a, ACK_TIMEOUT);
				$display("Simulation failed");
				$finish;
			end
		end while (!ack);
		q = dat_r;
		if (waited != 1) begin
			bus_errors++;
			$display("** Error at %0.1f ns: ack for %h came after %0d clocks",
				$realtime, a, waited);
		end
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		step_clock();  // idle clock between cycles
	endtask

	task automatic bus_write(input logic [`FDS_ADDR_W-1:0] a, input logic [`FDS_DATA_W-1:0] d);
		logic [`FDS_DATA_W-1:0] q;
		bus_access(1'b1, a, d, q);
	endtask

	task automatic bus_read(input logic [`FDS_ADDR_W-1:0] a, output logic [`FDS_DATA_W-1:0] q);
		bus_access(1'b0, a, 8'h00, q);
	endtask

	initial begin : stimulus
		logic [31:0]            r;
		logic [`FDS_DATA_W-1:0] q;
		int                     total;
		rng        = SEED;
		reset      = 1'b1;
		m2_tick    = 1'b0;
		cyc        = 1'b0;
		stb        = 1'b0;
		we         = 1'b0;
		adr        = '0;
		dat_w      = '0;
		ticking    = 1'b0;
		gap        = 0;
		bus_errors = 0;
		repeat (4) @(posedge clk20);
		#0.5;
		reset = 1'b0;

		bus_read(`FDS_RD_GAIN, q);  // gain after reset

		// fill the whole table in write mode and read back random entries
		bus_write(`FDS_REG_MASTER, 8'h80);
		for (int i = 0; i < 64; i++) begin
			roll(r);
			bus_write(`FDS_WAVE_BASE | {10'd0, i[5:0]}, r[7:0]);
		end
		for (int i = 0; i < 64; i++) begin
			roll(r);
			bus_read(`FDS_WAVE_BASE | {10'd0, r[5:0]}, q);
		end
		bus_read(`FDS_RD_SAMPLE, q);

		// running channel with each master volume twice and one halt
		ticking = 1'b1;
		bus_write(`FDS_REG_VOL, 8'h94);  // load gain 20, envelope stays off
		for (int i = 0; i < 8; i++) begin
			roll(r);
			bus_write(`FDS_REG_MASTER, {6'd0, i[1:0]});
			bus_write(`FDS_REG_FREQ_LO, r[15:8]);
			bus_write(`FDS_REG_FREQ_HI, {(i == 5), 1'b1, 2'b00, 1'b1, r[18:16]});
			run_clocks(4000);
			bus_read(`FDS_RD_SAMPLE, q);
		end

		// envelope with small speeds, random direction and halt
		for (int i = 0; i < 6; i++) begin
			roll(r);
			bus_write(`FDS_REG_ENV_SPEED, {6'd0, r[1:0]} + 8'd1);
			bus_write(`FDS_REG_FREQ_HI, {r[2], 1'b0, 2'b00, 1'b1, r[6:4]});
			bus_write(`FDS_REG_VOL, {2'b10, r[13:8] % 6'd33});
			bus_write(`FDS_REG_VOL, {1'b0, r[3], 4'b0000, r[17:16]});
			for (int k = 0; k < 12; k++) begin
				run_clocks(300);
				bus_read(`FDS_RD_GAIN, q);
				if (q[5:0] > 6'd32) begin
					bus_errors++;
					$display("** Error at %0.1f ns: gain %0d above 32", $realtime, q[5:0]);
				end
			end
			bus_read(`FDS_RD_SAMPLE, q);
		end

		run_clocks(20);
		total = ack_errors + data_errors + level_errors + bus_errors;
		$display("errors: ack %0d, read data %0d, level %0d, bus %0d",
			ack_errors, data_errors, level_errors, bus_errors);
		if (total == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/fds_audio_checker.sv
// per-clock comparison of dut ack, read data and audio level against the reference model
`timescale 1ns/1ps
`default_nettype none
`include "fds_audio_defs.svh"

module fds_audio_checker (
	input  wire                    clk20,
	input  wire                    reset,
	input  wire                    ack,
	input  wire [`FDS_DATA_W-1:0]  dat_r,
	input  wire [`FDS_LEVEL_W-1:0] audio_level,
	input  wire                    exp_ack,
	input  wire                    exp_read,   // current ack belongs to a read
	input  wire [`FDS_DATA_W-1:0]  exp_dat_r,
	input  wire [`FDS_LEVEL_W-1:0] exp_level,
	output int                     ack_errors,
	output int                     data_errors,
	output int                     level_errors
);

	// sampled on the falling edge away from the rising edge updates
	always @(negedge clk20) begin
		if (reset) begin
			ack_errors   = 0;
			data_errors  = 0;
			level_errors = 0;
		end else begin
			if (ack !== exp_ack) begin
				ack_errors = ack_errors + 1;
				$display("** Error at %0.1f ns: ack is %b, model expects %b",
					$realtime, ack, exp_ack);
			end
			// read data only means something while a read is acked
			if (exp_ack && exp_read && dat_r !== exp_dat_r) begin
				data_errors = data_errors + 1;
				$display("** Error at %0.1f ns: dat_r is %h, model expects %h",
					$realtime, dat_r, exp_dat_r);
			end
			if (audio_level !== exp_level) begin
				level_errors = level_errors + 1;
				$display("** Error at %0.1f ns: audio_level is %0d, model expects %0d",
					$realtime, audio_level, exp_level);
			end
		end
	end

endmodule

`default_nettype wire

//--- source/fds_audio_top.sv
// fds sound unit top, bus decode feeding wave channel, envelope and level mixer
`timescale 1ns/1ps
`default_nettype none
`include "fds_audio_defs.svh"

module fds_audio_top (
	input  wire                     clk20,
	input  wire                     reset,
	input  wire                     m2_tick,  // one clk20 pulse per cpu cycle
	input  wire                     cyc,
	input  wire                     stb,
	input  wire                     we,
	input  wire [`FDS_ADDR_W-1:0]   adr,
	input  wire [`FDS_DATA_W-1:0]   dat_w,
	output logic                    ack,
	output logic [`FDS_DATA_W-1:0]  dat_r,
	output logic [`FDS_LEVEL_W-1:0] audio_level
);
	import fds_audio_pkg::*;

	reg_cmd_t               cmd;   // decoded write, one clock
	chan_status_t           chan;
	logic [`FDS_GAIN_W-1:0] gain;

	fds_reg_decode u_decode (
		.clk20 (clk20),
		.reset (reset),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.chan  (chan),
		.gain  (gain),
		.ack   (ack),
		.dat_r (dat_r),
		.cmd   (cmd)
	);

	fds_wave_channel u_wave (
		.clk20   (clk20),
		.reset   (reset),
		.m2_tick (m2_tick),
		.cmd     (cmd),
		.chan    (chan)
	);

	fds_vol_envelope u_env (
		.clk20   (clk20),
		.reset   (reset),
		.m2_tick (m2_tick),
		.cmd     (cmd),
		.chan    (chan),   // halted speeds up ticks
		.gain    (gain)
	);

	fds_level_mix u_mix (
		.clk20       (clk20),
		.reset       (reset),
		.cmd         (cmd),
		.chan        (chan),
		.gain        (gain),
		.audio_level (audio_level)
	);

endmodule

`default_nettype wire

//--- source/fds_level_mix.sv
// volume latch, wave times volume, master volume scaling and output register
`timescale 1ns/1ps
`default_nettype none
`include "fds_audio_defs.svh"

module fds_level_mix (
	input  wire                               clk20,
	input  wire                               reset,
	input  wire fds_audio_pkg::reg_cmd_t      cmd,
	input  wire fds_audio_pkg::chan_status_t  chan,
	input  wire [`FDS_GAIN_W-1:0]             gain,
	output logic [`FDS_LEVEL_W-1:0]           audio_level
);
	import fds_audio_pkg::*;

	localparam logic [`FDS_LEVEL_W:0] div3 = 3;
	localparam logic [`FDS_LEVEL_W:0] div5 = 5;

	logic [1:0]              master_vol;  // $4089 bits 1:0
	logic [`FDS_GAIN_W-1:0]  vol_latch;
	logic [`FDS_GAIN_W-1:0]  vol_eff;
	logic [`FDS_LEVEL_W-1:0] raw;
	logic [`FDS_LEVEL_W:0]   raw_x2;
	logic [`FDS_LEVEL_W:0]   scaled;

	assign vol_eff = vol_latch[5] ? `FDS_VOL_CLAMP : vol_latch;  // clamp at 32
	assign raw     = {{(`FDS_LEVEL_W-`FDS_SAMPLE_W){1'b0}}, chan.sample} *
			{{(`FDS_LEVEL_W-`FDS_GAIN_W){1'b0}}, vol_eff};  // 63*32 max
	assign raw_x2  = {raw, 1'b0};

	always_comb begin
		case (master_vol)
			2'd0:    scaled = {1'b0, raw};                      // full
			2'd1:    scaled = raw_x2 / div3;                    // 2/3
			2'd2:    scaled = {2'b00, raw[`FDS_LEVEL_W-1:1]};   // 1/2
			default: scaled = raw_x2 / div5;                    // 2/5
		endcase
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			master_vol  <= 2'd0;
			vol_latch   <= '0;
			audio_level <= '0;
		end else begin
			if (cmd.valid && cmd.sel == sel_master)
				master_vol <= cmd.data[1:0];
			if (chan.phase_index == '0)
				vol_latch <= gain;  // only at wave start, avoids clicks
			audio_level <= scaled[`FDS_LEVEL_W-1:0];
		end
	end

endmodule

`default_nettype wire

//--- source/fds_vol_envelope.sv
// volume envelope registers, envelope tick counters and gain stepping
`timescale 1ns/1ps
`default_nettype none
`include "fds_audio_defs.svh"

module fds_vol_envelope (
	input  wire                               clk20,
	input  wire                               reset,
	input  wire                               m2_tick,
	input  wire fds_audio_pkg::reg_cmd_t      cmd,
	input  wire fds_audio_pkg::chan_status_t  chan,
	output logic [`FDS_GAIN_W-1:0]            gain
);
	import fds_audio_pkg::*;

	logic [5:0]                 vol_speed;  // periods per gain step, minus one
	logic                       vol_dir;    // 1 = up toward 32
	logic                       vol_off;    // $4080 bit 7
	logic                       env_off;    // $4083 bit 6
	logic [7:0]                 env_speed;
	logic [`FDS_ENV_TICK_W-1:0] env_ticks;
	logic [5:0]                 vol_ticks;
	logic                       env_run;
	logic [`FDS_ENV_TICK_W-1:0] period_last;
	logic [`FDS_ENV_TICK_W-1:0] tick_step;

	assign env_run     = !env_off && !vol_off && (env_speed != 8'd0);
	assign period_last = {{(`FDS_ENV_TICK_W-11){1'b0}}, env_speed, 3'b111};  // speed*8+7
	assign tick_step   = chan.halted ? `FDS_ENV_STEP_HALT : `FDS_ENV_STEP_RUN;

	always_ff @(posedge clk20) begin
		if (reset) begin
			vol_speed <= '0;
			vol_dir   <= 1'b0;
			vol_off   <= 1'b0;
			env_off   <= 1'b1;  // envelope stopped out of reset
			env_speed <= `FDS_ENV_SPEED_RESET;
			env_ticks <= '0;
			vol_ticks <= '0;
			gain      <= '0;
		end else begin
			if (m2_tick && env_run) begin
				if (env_ticks >= period_last) begin
					env_ticks <= '0;
					if (vol_ticks == vol_speed) begin
						vol_ticks <= '0;
						if (vol_dir && !gain[5])
							gain <= gain + 6'd1;  // stops at 32
						else if (!vol_dir && gain != '0)
							gain <= gain - 6'd1;
					end else
						vol_ticks <= vol_ticks + 6'd1;
				end else
					env_ticks <= env_ticks + tick_step;
			end

			if (cmd.valid) begin
				case (cmd.sel)
					sel_vol: begin
						{vol_off, vol_dir, vol_speed} <= cmd.data;
						if (cmd.data[`FDS_VOL_LOAD_BIT])
							gain <= cmd.data[`FDS_GAIN_W-1:0];  // direct gain load
						env_ticks <= '0;
						vol_ticks <= '0;
					end
					sel_freq_hi: begin
						env_off <= cmd.data[`FDS_ENV_OFF_BIT];
						if (cmd.data[`FDS_ENV_OFF_BIT]) begin
							env_ticks <= '0;
							vol_ticks <= '0;
						end
					end
					sel_env_speed: begin
						env_speed <= cmd.data;
						env_ticks <= '0;  // restart period
						vol_ticks <= '0;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- source/fds_wave_channel.sv
// wave table, frequency and halt registers, cycle counter and phase accumulator
`timescale 1ns/1ps
`default_nettype none
`include "fds_audio_defs.svh"

module fds_wave_channel (
	input  wire                           clk20,
	input  wire                           reset,
	input  wire                           m2_tick,
	input  wire fds_audio_pkg::reg_cmd_t  cmd,
	output fds_audio_pkg::chan_status_t   chan
);
	import fds_audio_pkg::*;

	logic [`FDS_SAMPLE_W-1:0] wave_table [`FDS_TABLE_DEPTH];
	logic [`FDS_FREQ_W-1:0]   freq;
	logic                     halted;      // $4083 bit 7
	logic                     write_mode;  // $4089 bit 7
	logic [3:0]               cycles;      // divides cpu clock by 16
	logic [`FDS_PHASE_W-1:0]  phase;
	logic [`FDS_SAMPLE_W-1:0] wave_latch;
	logic [`FDS_INDEX_W-1:0]  phase_index;
	logic [`FDS_PHASE_W-1:0]  pitch;

	assign phase_index = phase[`FDS_PHASE_W-1 -: `FDS_INDEX_W];
	assign pitch       = {{(`FDS_PHASE_W-`FDS_FREQ_W){1'b0}}, freq};  // no modulator

	// table port, cpu may only write while playback is frozen
	always_ff @(posedge clk20) begin
		if (cmd.valid && cmd.sel == sel_wave && write_mode)
			wave_table[cmd.index] <= cmd.data[`FDS_SAMPLE_W-1:0];
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			freq       <= '0;
			halted     <= 1'b1;  // silent until first $4083 write
			write_mode <= 1'b0;
			cycles     <= '0;
			phase      <= '0;
			wave_latch <= '0;
		end else begin
			if (m2_tick) begin
				cycles <= halted ? 4'd0 : cycles + 4'd1;
				if (cycles == 4'hF && !halted)
					phase <= phase + pitch;  // step every 16 cpu cycles
				if (!write_mode)
					wave_latch <= wave_table[phase_index];  // frozen in write mode
			end

			// register writes win over the tick
			if (cmd.valid) begin
				case (cmd.sel)
					sel_freq_lo: freq[7:0] <= cmd.data;
					sel_freq_hi: begin
						freq[`FDS_FREQ_W-1:8] <= cmd.data[3:0];
						halted                <= cmd.data[`FDS_HALT_BIT];
						if (cmd.data[`FDS_HALT_BIT]) begin
							phase  <= '0;  // halt restarts the wave
							cycles <= '0;
						end
					end
					sel_master: write_mode <= cmd.data[`FDS_WREN_BIT];
					default: ;  // not ours
				endcase
			end
		end
	end

	always_comb begin
		chan.halted      = halted;
		chan.phase_index = phase_index;
		chan.sample      = wave_latch;
		// bus sees the addressed word only while writing is allowed
		chan.rd_sample   = write_mode ? wave_table[cmd.index] : wave_table[phase_index];
	end

endmodule

`default_nettype wire

//--- source/fds_reg_decode.sv
// wishbone classic slave with write command decode and registered readback mux
`timescale 1ns/1ps
`default_nettype none
`include "fds_audio_defs.svh"

module fds_reg_decode (
	input  wire                               clk20,
	input  wire                               reset,
	input  wire                               cyc,
	input  wire                               stb,
	input  wire                               we,
	input  wire [`FDS_ADDR_W-1:0]             adr,
	input  wire [`FDS_DATA_W-1:0]             dat_w,
	input  wire fds_audio_pkg::chan_status_t  chan,
	input  wire [`FDS_GAIN_W-1:0]             gain,
	output logic                              ack,
	output logic [`FDS_DATA_W-1:0]            dat_r,
	output fds_audio_pkg::reg_cmd_t           cmd
);
	import fds_audio_pkg::*;

	logic     req;        // request not yet acked
	logic     in_window;  // $4040-$407f
	reg_sel_e wr_sel;
	rd_sel_e  rd_sel;

	assign req       = cyc & stb & ~ack;
	assign in_window = (adr >= `FDS_WAVE_BASE) && (adr <= `FDS_WAVE_LAST);

	// address to write target
	always_comb begin
		wr_sel = sel_none;
		if (in_window)
			wr_sel = sel_wave;
		else begin
			case (adr)
				`FDS_REG_VOL:       wr_sel = sel_vol;
				`FDS_REG_FREQ_LO:   wr_sel = sel_freq_lo;
				`FDS_REG_FREQ_HI:   wr_sel = sel_freq_hi;
				`FDS_REG_MASTER:    wr_sel = sel_master;
				`FDS_REG_ENV_SPEED: wr_sel = sel_env_speed;
				default:            wr_sel = sel_none;  // unmapped writes dropped
			endcase
		end
	end

	// address to read source
	always_comb begin
		if (in_window)
			rd_sel = rd_wave;
		else if (adr == `FDS_RD_GAIN)
			rd_sel = rd_gain;
		else if (adr == `FDS_RD_SAMPLE)
			rd_sel = rd_sample;
		else
			rd_sel = rd_default;
	end

	// write strobe lands on the edge that raises ack
	always_comb begin
		cmd.valid = req & we;
		cmd.sel   = wr_sel;
		cmd.index = adr[`FDS_INDEX_W-1:0];  // also selects the table word on reads
		cmd.data  = dat_w;
	end

	always_ff @(posedge clk20) begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= req;  // one clock wait state, one clock wide
	end

	// read data taken with ack
	always_ff @(posedge clk20) begin
		if (req && !we) begin
			case (rd_sel)
				rd_gain:   dat_r <= {2'b01, gain};
				rd_sample: dat_r <= {2'b01, chan.rd_sample};
				rd_wave:   dat_r <= {2'b00, chan.rd_sample};  // raw table word
				default:   dat_r <= `FDS_RD_DEFAULT;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/fds_audio_pkg.sv
// shared enums and packed structs for the fds sound unit
`default_nettype none
`include "fds_audio_defs.svh"

package fds_audio_pkg;

	// decoded write target
	typedef enum logic [2:0] {
		sel_none      = 3'd0,
		sel_wave      = 3'd1,  // $4040-$407f
		sel_vol       = 3'd2,  // $4080
		sel_freq_lo   = 3'd3,  // $4082
		sel_freq_hi   = 3'd4,  // $4083
		sel_master    = 3'd5,  // $4089
		sel_env_speed = 3'd6   // $408a
	} reg_sel_e;

	// readback source
	typedef enum logic [1:0] {
		rd_gain    = 2'd0,  // $4090
		rd_sample  = 2'd1,  // $4096
		rd_wave    = 2'd2,  // table window
		rd_default = 2'd3   // everything else
	} rd_sel_e;

	// one write from the bus, 18 bits
	typedef struct packed {
		logic                    valid;  // single clock strobe
		reg_sel_e                sel;
		logic [`FDS_INDEX_W-1:0] index;  // low address bits, also used for table reads
		logic [`FDS_DATA_W-1:0]  data;
	} reg_cmd_t;

	// wave channel status, 19 bits
	typedef struct packed {
		logic                     halted;
		logic [`FDS_INDEX_W-1:0]  phase_index;  // top of phase accumulator
		logic [`FDS_SAMPLE_W-1:0] sample;       // latched wave value
		logic [`FDS_SAMPLE_W-1:0] rd_sample;    // table value seen by the bus
	} chan_status_t;

endpackage

`default_nettype wire

//--- include/fds_audio_defs.svh
// bus addresses, field widths, bit positions and envelope constants of the fds sound unit
`ifndef FDS_AUDIO_DEFS_SVH
`define FDS_AUDIO_DEFS_SVH

// cpu bus
`define FDS_ADDR_W          16
`define FDS_DATA_W          8

// write targets
`define FDS_WAVE_BASE       16'h4040  // wave table window start
`define FDS_WAVE_LAST       16'h407F  // wave table window end
`define FDS_REG_VOL         16'h4080  // volume envelope control
`define FDS_REG_FREQ_LO     16'h4082
`define FDS_REG_FREQ_HI     16'h4083  // freq high nibble, halt, env off
`define FDS_REG_MASTER      16'h4089  // write mode, master volume
`define FDS_REG_ENV_SPEED   16'h408A

// readback
`define FDS_RD_GAIN         16'h4090
`define FDS_RD_SAMPLE       16'h4096
`define FDS_RD_DEFAULT      8'h40     // open bus value

// field widths
`define FDS_GAIN_W          6
`define FDS_SAMPLE_W        6
`define FDS_PHASE_W         24
`define FDS_FREQ_W          12
`define FDS_LEVEL_W         12
`define FDS_INDEX_W         6
`define FDS_TABLE_DEPTH     64
`define FDS_ENV_TICK_W      12

// control bit positions
`define FDS_HALT_BIT        7   // $4083
`define FDS_ENV_OFF_BIT     6   // $4083
`define FDS_WREN_BIT        7   // $4089
`define FDS_VOL_LOAD_BIT    7   // $4080

// envelope
`define FDS_ENV_SPEED_RESET 8'hE8
`define FDS_ENV_STEP_RUN    12'd1
`define FDS_ENV_STEP_HALT   12'd4  // faster ticks while halted
`define FDS_VOL_CLAMP       6'd32

`endif
